// ==== sources.f ====
source/csr_pkg.sv
source/csr_write_decode.sv
source/csr_trap_unit.sv
source/csr_reg_bank.sv
source/csr_read_mux.sv
source/csr_file.sv
+incdir+testbench
testbench/csr_file_assert.sv
testbench/csr_file_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module csr_file_tb
output=$(./obj_dir/Vcsr_file_tb)
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== testbench/csr_file_tests.svh ====
// CSR file directed tests

// ----------------------------------------
// Helpers
// ----------------------------------------

function automatic csr_pkg::word_t bit_mask(input int pos);
    bit_mask = csr_pkg::word_t'(1) << pos;
endfunction

task automatic check_value(input string name, input csr_pkg::word_t got,
                           input csr_pkg::word_t expected);
    assert (got === expected) else begin
        error_count++;
        $display("Error: %s is %h, expected %h", name, got, expected);
    end
endtask

// Tasks start and end just after a rising edge
task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t data);
    write_en <= 1'b1;
    write_addr <= addr;
    write_data <= data;
    @(posedge clk);
    write_en <= 1'b0;
endtask

task automatic read_and_check(input string name, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::word_t expected);
    read_addr <= addr;
    @(negedge clk);
    check_value(name, read_data, expected);
    @(posedge clk);
endtask

task automatic write_and_read_back(input string name, input csr_pkg::csr_addr_t addr,
                                   output csr_pkg::word_t data);
    data = $urandom;
    write_csr(addr, data);
    read_and_check(name, addr, data);
endtask

task automatic check_priv_status(input csr_pkg::priv_t exp_priv,
                                 input csr_pkg::word_t exp_status);
    @(negedge clk);
    check_value("priv", csr_pkg::word_t'(priv), csr_pkg::word_t'(exp_priv));
    check_value("status", status, exp_status);
    @(posedge clk);
endtask

task automatic raise_trap(input logic is_int, input csr_pkg::cause_code_t code,
                          input csr_pkg::word_t value, input csr_pkg::word_t pc);
    trap_valid <= 1'b1;
    trap_is_interrupt <= is_int;
    trap_code <= code;
    trap_value <= value;
    trap_pc <= pc;
    @(posedge clk);
    trap_valid <= 1'b0;
endtask

task automatic return_from_trap(input csr_pkg::priv_t level);
    trap_return <= 1'b1;
    trap_return_priv <= level;
    @(posedge clk);
    trap_return <= 1'b0;
endtask

// ----------------------------------------
// Tests
// ----------------------------------------

task automatic reset_and_constants();
    // MXL = 1 in bits 31:30, letters I and S
    check_priv_status(csr_pkg::PRIV_MACHINE, '0);
    read_and_check("misa", csr_pkg::CSR_MISA, bit_mask(30) | bit_mask(8) | bit_mask(18));
    read_and_check("mhartid", csr_pkg::CSR_MHARTID, 32'd5);
    read_and_check("mvendorid", csr_pkg::CSR_MVENDORID, '0);
    read_and_check("unknown csr", 12'h7c0, '0);
endtask

task automatic register_writes();
    csr_pkg::word_t data;
    csr_pkg::word_t mtvec_data;
    csr_pkg::word_t stvec_data;
    csr_pkg::word_t mepc_data;
    csr_pkg::word_t sepc_data;
    write_and_read_back("mtvec", csr_pkg::CSR_MTVEC, mtvec_data);
    write_and_read_back("stvec", csr_pkg::CSR_STVEC, stvec_data);
    write_and_read_back("mscratch", csr_pkg::CSR_MSCRATCH, data);
    write_and_read_back("sscratch", csr_pkg::CSR_SSCRATCH, data);
    write_and_read_back("mepc", csr_pkg::CSR_MEPC, mepc_data);
    write_and_read_back("sepc", csr_pkg::CSR_SEPC, sepc_data);

    // Vectors and return addresses on the output ports
    @(negedge clk);
    check_value("mtvec port", mtvec, mtvec_data);
    check_value("stvec port", stvec, stvec_data);
    check_value("mepc port", mepc, mepc_data);
    check_value("sepc port", sepc, sepc_data);
    @(posedge clk);

    write_csr(csr_pkg::CSR_SSTATUS, '1);
    read_and_check("mstatus", csr_pkg::CSR_MSTATUS,
                   bit_mask(1) | bit_mask(5) | bit_mask(8));
    data = $urandom;
    write_csr(csr_pkg::CSR_MCAUSE, data);
    read_and_check("mcause", csr_pkg::CSR_MCAUSE, data & 32'h8000_000f);
endtask

task automatic machine_trap();
    logic                 is_int;
    csr_pkg::cause_code_t code;
    csr_pkg::word_t       pc;
    csr_pkg::word_t       value;
    is_int = ($urandom & 32'h1) != 0;
    code = csr_pkg::cause_code_t'($urandom_range(15, 0));
    pc = $urandom & 32'hffff_fffc;
    value = $urandom;
    write_csr(csr_pkg::CSR_MEDELEG, '0);
    write_csr(csr_pkg::CSR_MSTATUS, bit_mask(3));
    raise_trap(is_int, code, value, pc);
    // MPIE from MIE, MPP holds machine
    check_priv_status(csr_pkg::PRIV_MACHINE, bit_mask(7) | (32'd3 << 11));
    read_and_check("mepc", csr_pkg::CSR_MEPC, pc);
    read_and_check("mcause", csr_pkg::CSR_MCAUSE, {is_int, 27'd0, code});
    read_and_check("mtval", csr_pkg::CSR_MTVAL, value);
    @(negedge clk);
    check_value("mepc port", mepc, pc);
    @(posedge clk);
endtask

task automatic delegated_trap();
    csr_pkg::cause_code_t code;
    csr_pkg::word_t       pc;
    csr_pkg::word_t       value;
    code = csr_pkg::cause_code_t'($urandom_range(15, 0));
    pc = $urandom & 32'hffff_fffc;
    value = $urandom;
    write_csr(csr_pkg::CSR_MEDELEG, bit_mask(int'(code)));

    // Drop to supervisor, SIE set, MPIE clear
    write_csr(csr_pkg::CSR_MSTATUS, bit_mask(1) | (32'd1 << 11));
    return_from_trap(csr_pkg::PRIV_MACHINE);
    check_priv_status(csr_pkg::PRIV_SUPERVISOR, bit_mask(1));

    raise_trap(1'b0, code, value, pc);
    check_priv_status(csr_pkg::PRIV_SUPERVISOR, bit_mask(5) | bit_mask(8));
    read_and_check("sepc", csr_pkg::CSR_SEPC, pc);
    read_and_check("scause", csr_pkg::CSR_SCAUSE, {28'd0, code});
    read_and_check("stval", csr_pkg::CSR_STVAL, value);
    @(negedge clk);
    check_value("sepc port", sepc, pc);
    @(posedge clk);

    // mret to machine with MPIE set
    write_csr(csr_pkg::CSR_MSTATUS,
              bit_mask(5) | bit_mask(8) | bit_mask(7) | (32'd3 << 11));
    return_from_trap(csr_pkg::PRIV_MACHINE);
    check_priv_status(csr_pkg::PRIV_MACHINE,
                      bit_mask(5) | bit_mask(8) | bit_mask(7) | bit_mask(3));

    // sret back to supervisor, SPP cleared to user
    return_from_trap(csr_pkg::PRIV_SUPERVISOR);
    check_priv_status(csr_pkg::PRIV_SUPERVISOR,
                      bit_mask(5) | bit_mask(7) | bit_mask(3) | bit_mask(1));
endtask

task automatic cycle_counter();
    csr_pkg::word_t first;
    csr_pkg::word_t second;
    int             gap;
    gap = int'($urandom_range(20, 1));
    read_addr <= csr_pkg::CSR_CYCLE;
    @(negedge clk);
    first = read_data;
    repeat (gap) @(negedge clk);
    second = read_data;
    check_value("cycle delta", second - first, csr_pkg::word_t'(gap));
    check_value("cycle", read_data, edge_count[31:0]);
    @(posedge clk);
    read_addr <= csr_pkg::CSR_CYCLEH;
    @(negedge clk);
    check_value("cycleh", read_data, edge_count[63:32]);
    @(posedge clk);
endtask

// ==== testbench/csr_file_tb.sv ====
// CSR file testbench

`timescale 1ns/100ps

module csr_file_tb;

    localparam csr_pkg::word_t HART_ID = 32'd5;
    localparam int RANDOM_SEED = 98759;
    // About 120 cycles of tests plus reset, with margin
    localparam int TIMEOUT_CYCLES = 400;

    logic                 clk;
    logic                 rst;
    csr_pkg::csr_addr_t   read_addr;
    csr_pkg::word_t       read_data;
    logic                 write_en;
    csr_pkg::csr_addr_t   write_addr;
    csr_pkg::word_t       write_data;
    logic                 trap_valid;
    logic                 trap_is_interrupt;
    csr_pkg::cause_code_t trap_code;
    csr_pkg::word_t       trap_value;
    csr_pkg::word_t       trap_pc;
    logic                 trap_return;
    csr_pkg::priv_t       trap_return_priv;
    csr_pkg::priv_t       priv;
    csr_pkg::word_t       status;
    csr_pkg::word_t       mtvec;
    csr_pkg::word_t       stvec;
    csr_pkg::word_t       mepc;
    csr_pkg::word_t       sepc;

    int              error_count = 0;
    int              timeout_count = 0;
    // Edges seen with reset released, the expected cycle count
    csr_pkg::dword_t edge_count = '0;

    csr_file #(
        .HART_ID (HART_ID)
    ) i_csr_file (
        .clk               (clk),
        .rst               (rst),
        .read_addr         (read_addr),
        .read_data         (read_data),
        .write_en          (write_en),
        .write_addr        (write_addr),
        .write_data        (write_data),
        .trap_valid        (trap_valid),
        .trap_is_interrupt (trap_is_interrupt),
        .trap_code         (trap_code),
        .trap_value        (trap_value),
        .trap_pc           (trap_pc),
        .trap_return       (trap_return),
        .trap_return_priv  (trap_return_priv),
        .priv              (priv),
        .status            (status),
        .mtvec             (mtvec),
        .stvec             (stvec),
        .mepc              (mepc),
        .sepc              (sepc)
    );

    `include "csr_file_tests.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            edge_count <= edge_count + 64'd1;
        end
    end

    always @(posedge clk) begin
        timeout_count <= timeout_count + 1;
        if (timeout_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        void'($urandom(RANDOM_SEED));
        rst <= 1'b1;
        read_addr <= '0;
        write_en <= 1'b0;
        write_addr <= '0;
        write_data <= '0;
        trap_valid <= 1'b0;
        trap_is_interrupt <= 1'b0;
        trap_code <= '0;
        trap_value <= '0;
        trap_pc <= '0;
        trap_return <= 1'b0;
        trap_return_priv <= csr_pkg::PRIV_USER;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        reset_and_constants();
        register_writes();
        machine_trap();
        delegated_trap();
        cycle_counter();

        @(posedge clk);
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/csr_file_assert.sv ====
// CSR file assertions

`timescale 1ns/100ps

module csr_file_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 trap_valid,
    input csr_pkg::cause_code_t trap_code,
    input csr_pkg::word_t       medeleg,
    input csr_pkg::priv_t       priv,
    input csr_pkg::word_t       status
);

    // Encoding 2 is reserved
    priv_legal: assert property (@(posedge clk) disable iff (rst) priv != 2'd2)
        else $error("priv took the reserved encoding 2");

    trap_m_disables: assert property (@(posedge clk) disable iff (rst)
        trap_valid && !medeleg[trap_code] |=> !status[csr_pkg::STATUS_MIE])
        else $error("MIE still set one cycle after a trap to machine");

    trap_s_disables: assert property (@(posedge clk) disable iff (rst)
        trap_valid && medeleg[trap_code] |=> !status[csr_pkg::STATUS_SIE])
        else $error("SIE still set one cycle after a trap to supervisor");

    status_masked: assert property (@(posedge clk) disable iff (rst)
        (status & ~csr_pkg::MSTATUS_WRITE_MASK) == '0)
        else $error("status has bits set outside the implemented fields");

endmodule

bind csr_file csr_file_assert i_csr_file_assert (
    .clk        (clk),
    .rst        (rst),
    .trap_valid (trap_valid),
    .trap_code  (trap_code),
    .medeleg    (medeleg),
    .priv       (priv),
    .status     (status)
);

// ==== source/csr_file.sv ====
// Machine/supervisor CSR file

`timescale 1ns/100ps

module csr_file #(
    parameter csr_pkg::word_t HART_ID = '0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_addr_t   read_addr,
    output csr_pkg::word_t       read_data,
    input  logic                 write_en,
    input  csr_pkg::csr_addr_t   write_addr,
    input  csr_pkg::word_t       write_data,
    input  logic                 trap_valid,
    input  logic                 trap_is_interrupt,
    input  csr_pkg::cause_code_t trap_code,
    input  csr_pkg::word_t       trap_value,
    input  csr_pkg::word_t       trap_pc,
    input  logic                 trap_return,
    input  csr_pkg::priv_t       trap_return_priv,
    output csr_pkg::priv_t       priv,
    output csr_pkg::word_t       status,
    output csr_pkg::word_t       mtvec,
    output csr_pkg::word_t       stvec,
    output csr_pkg::word_t       mepc,
    output csr_pkg::word_t       sepc
);

    // Write strobes
    logic wr_mstatus;
    logic wr_sstatus;
    logic wr_medeleg;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_stvec;
    logic wr_sscratch;
    logic wr_sepc;
    logic wr_scause;
    logic wr_stval;

    // Register values seen only by the read path
    csr_pkg::word_t  medeleg;
    csr_pkg::word_t  mscratch;
    csr_pkg::word_t  mcause;
    csr_pkg::word_t  mtval;
    csr_pkg::word_t  sscratch;
    csr_pkg::word_t  scause;
    csr_pkg::word_t  stval;
    csr_pkg::dword_t cycle;

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    csr_write_decode i_write_decode (
        .write_en    (write_en),
        .write_addr  (write_addr),
        .wr_mstatus  (wr_mstatus),
        .wr_sstatus  (wr_sstatus),
        .wr_medeleg  (wr_medeleg),
        .wr_mtvec    (wr_mtvec),
        .wr_mscratch (wr_mscratch),
        .wr_mepc     (wr_mepc),
        .wr_mcause   (wr_mcause),
        .wr_mtval    (wr_mtval),
        .wr_stvec    (wr_stvec),
        .wr_sscratch (wr_sscratch),
        .wr_sepc     (wr_sepc),
        .wr_scause   (wr_scause),
        .wr_stval    (wr_stval)
    );

    // ----------------------------------------
    // Execute
    // ----------------------------------------

    csr_trap_unit i_trap_unit (
        .clk               (clk),
        .rst               (rst),
        .trap_valid        (trap_valid),
        .trap_is_interrupt (trap_is_interrupt),
        .trap_code         (trap_code),
        .trap_value        (trap_value),
        .trap_pc           (trap_pc),
        .trap_return       (trap_return),
        .trap_return_priv  (trap_return_priv),
        .medeleg           (medeleg),
        .write_data        (write_data),
        .wr_mstatus        (wr_mstatus),
        .wr_sstatus        (wr_sstatus),
        .wr_mepc           (wr_mepc),
        .wr_mcause         (wr_mcause),
        .wr_mtval          (wr_mtval),
        .wr_sepc           (wr_sepc),
        .wr_scause         (wr_scause),
        .wr_stval          (wr_stval),
        .priv              (priv),
        .status            (status),
        .mepc              (mepc),
        .mcause            (mcause),
        .mtval             (mtval),
        .sepc              (sepc),
        .scause            (scause),
        .stval             (stval)
    );

    csr_reg_bank i_reg_bank (
        .clk         (clk),
        .rst         (rst),
        .write_data  (write_data),
        .wr_medeleg  (wr_medeleg),
        .wr_mtvec    (wr_mtvec),
        .wr_mscratch (wr_mscratch),
        .wr_stvec    (wr_stvec),
        .wr_sscratch (wr_sscratch),
        .medeleg     (medeleg),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .stvec       (stvec),
        .sscratch    (sscratch),
        .cycle       (cycle)
    );

    // ----------------------------------------
    // Result
    // ----------------------------------------

    csr_read_mux #(
        .HART_ID (HART_ID)
    ) i_read_mux (
        .read_addr (read_addr),
        .status    (status),
        .medeleg   (medeleg),
        .mtvec     (mtvec),
        .mscratch  (mscratch),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval),
        .stvec     (stvec),
        .sscratch  (sscratch),
        .sepc      (sepc),
        .scause    (scause),
        .stval     (stval),
        .cycle     (cycle),
        .read_data (read_data)
    );

endmodule

// ==== source/csr_read_mux.sv ====
// CSR read multiplexer

`timescale 1ns/100ps

module csr_read_mux #(
    parameter csr_pkg::word_t HART_ID = '0
) (
    input  csr_pkg::csr_addr_t read_addr,
    input  csr_pkg::word_t     status,
    input  csr_pkg::word_t     medeleg,
    input  csr_pkg::word_t     mtvec,
    input  csr_pkg::word_t     mscratch,
    input  csr_pkg::word_t     mepc,
    input  csr_pkg::word_t     mcause,
    input  csr_pkg::word_t     mtval,
    input  csr_pkg::word_t     stvec,
    input  csr_pkg::word_t     sscratch,
    input  csr_pkg::word_t     sepc,
    input  csr_pkg::word_t     scause,
    input  csr_pkg::word_t     stval,
    input  csr_pkg::dword_t    cycle,
    output csr_pkg::word_t     read_data
);

    always_comb begin
        case (read_addr)
            // Supervisor view of the shared status register
            csr_pkg::CSR_SSTATUS:   read_data = status & csr_pkg::SSTATUS_MASK;
            csr_pkg::CSR_STVEC:     read_data = stvec;
            csr_pkg::CSR_SSCRATCH:  read_data = sscratch;
            csr_pkg::CSR_SEPC:      read_data = sepc;
            csr_pkg::CSR_SCAUSE:    read_data = scause;
            csr_pkg::CSR_STVAL:     read_data = stval;

            csr_pkg::CSR_MSTATUS:   read_data = status;
            csr_pkg::CSR_MISA:      read_data = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MEDELEG:   read_data = medeleg;
            csr_pkg::CSR_MTVEC:     read_data = mtvec;
            csr_pkg::CSR_MSCRATCH:  read_data = mscratch;
            csr_pkg::CSR_MEPC:      read_data = mepc;
            csr_pkg::CSR_MCAUSE:    read_data = mcause;
            csr_pkg::CSR_MTVAL:     read_data = mtval;

            csr_pkg::CSR_CYCLE:     read_data = cycle[31:0];
            csr_pkg::CSR_CYCLEH:    read_data = cycle[63:32];

            // Non-commercial, no arch or impl ID
            csr_pkg::CSR_MVENDORID: read_data = '0;
            csr_pkg::CSR_MARCHID:   read_data = '0;
            csr_pkg::CSR_MIMPID:    read_data = '0;
            csr_pkg::CSR_MHARTID:   read_data = HART_ID;

            default:                read_data = '0;
        endcase
    end

endmodule

// ==== source/csr_reg_bank.sv ====
// CSR-only registers and cycle counter

`timescale 1ns/100ps

module csr_reg_bank (
    input  logic            clk,
    input  logic            rst,
    input  csr_pkg::word_t  write_data,
    input  logic            wr_medeleg,
    input  logic            wr_mtvec,
    input  logic            wr_mscratch,
    input  logic            wr_stvec,
    input  logic            wr_sscratch,
    output csr_pkg::word_t  medeleg,
    output csr_pkg::word_t  mtvec,
    output csr_pkg::word_t  mscratch,
    output csr_pkg::word_t  stvec,
    output csr_pkg::word_t  sscratch,
    output csr_pkg::dword_t cycle
);

    // Machine level
    always_ff @(posedge clk) begin
        if (rst) begin
            medeleg  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
        end else begin
            if (wr_medeleg) begin
                medeleg <= write_data;
            end
            if (wr_mtvec) begin
                mtvec <= write_data;
            end
            if (wr_mscratch) begin
                mscratch <= write_data;
            end
        end
    end

    // Supervisor level
    always_ff @(posedge clk) begin
        if (rst) begin
            stvec    <= '0;
            sscratch <= '0;
        end else begin
            if (wr_stvec) begin
                stvec <= write_data;
            end
            if (wr_sscratch) begin
                sscratch <= write_data;
            end
        end
    end

    // Free running, wraps at 2^64
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

endmodule

// ==== source/csr_trap_unit.sv ====
// Trap and privilege state

`timescale 1ns/100ps

module csr_trap_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 trap_valid,
    input  logic                 trap_is_interrupt,
    input  csr_pkg::cause_code_t trap_code,
    input  csr_pkg::word_t       trap_value,
    input  csr_pkg::word_t       trap_pc,
    input  logic                 trap_return,
    input  csr_pkg::priv_t       trap_return_priv,
    input  csr_pkg::word_t       medeleg,
    input  csr_pkg::word_t       write_data,
    input  logic                 wr_mstatus,
    input  logic                 wr_sstatus,
    input  logic                 wr_mepc,
    input  logic                 wr_mcause,
    input  logic                 wr_mtval,
    input  logic                 wr_sepc,
    input  logic                 wr_scause,
    input  logic                 wr_stval,
    output csr_pkg::priv_t       priv,
    output csr_pkg::word_t       status,
    output csr_pkg::word_t       mepc,
    output csr_pkg::word_t       mcause,
    output csr_pkg::word_t       mtval,
    output csr_pkg::word_t       sepc,
    output csr_pkg::word_t       scause,
    output csr_pkg::word_t       stval
);

    localparam int CODE_W = $bits(csr_pkg::cause_code_t);

    // Interrupt flag plus the code bits
    localparam csr_pkg::word_t CAUSE_WRITE_MASK =
        (csr_pkg::word_t'(1) << csr_pkg::CAUSE_INT_BIT) | csr_pkg::word_t'({CODE_W{1'b1}});

    logic           trap_to_m;
    logic           trap_to_s;
    logic           do_mret;
    logic           do_sret;
    csr_pkg::word_t cause_word;
    csr_pkg::priv_t priv_next;
    csr_pkg::word_t status_next;

    // Delegated exceptions go to supervisor
    assign trap_to_s = trap_valid && medeleg[trap_code];
    assign trap_to_m = trap_valid && !medeleg[trap_code];

    // A trap in the same cycle wins over a return
    assign do_mret = !trap_valid && trap_return && (trap_return_priv == csr_pkg::PRIV_MACHINE);
    assign do_sret = !trap_valid && trap_return && (trap_return_priv == csr_pkg::PRIV_SUPERVISOR);

    always_comb begin
        cause_word = '0;
        cause_word[csr_pkg::CAUSE_INT_BIT] = trap_is_interrupt;
        cause_word[CODE_W-1:0] = trap_code;
    end

    // ----------------------------------------
    // Next privilege and status
    // ----------------------------------------

    always_comb begin
        priv_next   = priv;
        status_next = status;

        if (trap_to_m) begin
            priv_next = csr_pkg::PRIV_MACHINE;
            status_next[csr_pkg::STATUS_MPIE] = status[csr_pkg::STATUS_MIE];
            status_next[csr_pkg::STATUS_MIE] = 1'b0;
            status_next[csr_pkg::STATUS_MPP +: 2] = priv;
        end else if (trap_to_s) begin
            priv_next = csr_pkg::PRIV_SUPERVISOR;
            status_next[csr_pkg::STATUS_SPIE] = status[csr_pkg::STATUS_SIE];
            status_next[csr_pkg::STATUS_SIE] = 1'b0;
            status_next[csr_pkg::STATUS_SPP] = priv[0];
        end else if (do_mret) begin
            priv_next = status[csr_pkg::STATUS_MPP +: 2];
            status_next[csr_pkg::STATUS_MIE] = status[csr_pkg::STATUS_MPIE];
            status_next[csr_pkg::STATUS_MPP +: 2] = csr_pkg::PRIV_USER;
        end else if (do_sret) begin
            priv_next = {1'b0, status[csr_pkg::STATUS_SPP]};
            status_next[csr_pkg::STATUS_SIE] = status[csr_pkg::STATUS_SPIE];
            status_next[csr_pkg::STATUS_SPP] = csr_pkg::PRIV_USER[0];
        end else if (!trap_return && wr_mstatus) begin
            status_next = write_data & csr_pkg::MSTATUS_WRITE_MASK;
        end else if (!trap_return && wr_sstatus) begin
            status_next = (status & ~csr_pkg::SSTATUS_MASK)
                        | (write_data & csr_pkg::SSTATUS_MASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv   <= csr_pkg::PRIV_MACHINE;
            status <= '0;
        end else begin
            priv   <= priv_next;
            status <= status_next;
        end
    end

    // ----------------------------------------
    // Saved trap state per level
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
            sepc   <= '0;
            scause <= '0;
            stval  <= '0;
        end else begin
            if (trap_to_m) begin
                mepc   <= trap_pc;
                mcause <= cause_word;
                mtval  <= trap_value;
            end else begin
                if (wr_mepc) mepc <= write_data;
                if (wr_mcause) mcause <= write_data & CAUSE_WRITE_MASK;
                if (wr_mtval) mtval <= write_data;
            end

            if (trap_to_s) begin
                sepc   <= trap_pc;
                scause <= cause_word;
                stval  <= trap_value;
            end else begin
                if (wr_sepc) sepc <= write_data;
                if (wr_scause) scause <= write_data & CAUSE_WRITE_MASK;
                if (wr_stval) stval <= write_data;
            end
        end
    end

endmodule

// ==== source/csr_write_decode.sv ====
// CSR write address decoder

`timescale 1ns/100ps

module csr_write_decode (
    input  logic               write_en,
    input  csr_pkg::csr_addr_t write_addr,
    output logic               wr_mstatus,
    output logic               wr_sstatus,
    output logic               wr_medeleg,
    output logic               wr_mtvec,
    output logic               wr_mscratch,
    output logic               wr_mepc,
    output logic               wr_mcause,
    output logic               wr_mtval,
    output logic               wr_stvec,
    output logic               wr_sscratch,
    output logic               wr_sepc,
    output logic               wr_scause,
    output logic               wr_stval
);

    // Status registers
    assign wr_mstatus  = write_en && (write_addr == csr_pkg::CSR_MSTATUS);
    assign wr_sstatus  = write_en && (write_addr == csr_pkg::CSR_SSTATUS);

    // Machine level
    assign wr_medeleg  = write_en && (write_addr == csr_pkg::CSR_MEDELEG);
    assign wr_mtvec    = write_en && (write_addr == csr_pkg::CSR_MTVEC);
    assign wr_mscratch = write_en && (write_addr == csr_pkg::CSR_MSCRATCH);
    assign wr_mepc     = write_en && (write_addr == csr_pkg::CSR_MEPC);
    assign wr_mcause   = write_en && (write_addr == csr_pkg::CSR_MCAUSE);
    assign wr_mtval    = write_en && (write_addr == csr_pkg::CSR_MTVAL);

    // Supervisor level
    assign wr_stvec    = write_en && (write_addr == csr_pkg::CSR_STVEC);
    assign wr_sscratch = write_en && (write_addr == csr_pkg::CSR_SSCRATCH);
    assign wr_sepc     = write_en && (write_addr == csr_pkg::CSR_SEPC);
    assign wr_scause   = write_en && (write_addr == csr_pkg::CSR_SCAUSE);
    assign wr_stval    = write_en && (write_addr == csr_pkg::CSR_STVAL);

endmodule

// ==== source/csr_pkg.sv ====
// CSR file shared definitions

package csr_pkg;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] dword_t;
    typedef logic [3:0]  cause_code_t;

    // Privilege level, encoding 2 is reserved
    typedef logic [1:0]  priv_t;

    localparam priv_t PRIV_USER       = 2'd0;
    localparam priv_t PRIV_SUPERVISOR = 2'd1;
    localparam priv_t PRIV_MACHINE    = 2'd3;

    // ----------------------------------------
    // CSR addresses
    // ----------------------------------------

    // Supervisor level
    localparam csr_addr_t CSR_SSTATUS   = 12'h100;
    localparam csr_addr_t CSR_STVEC     = 12'h105;
    localparam csr_addr_t CSR_SSCRATCH  = 12'h140;
    localparam csr_addr_t CSR_SEPC      = 12'h141;
    localparam csr_addr_t CSR_SCAUSE    = 12'h142;
    localparam csr_addr_t CSR_STVAL     = 12'h143;

    // Machine level
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MEDELEG   = 12'h302;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;

    // Counters, read only
    localparam csr_addr_t CSR_CYCLE     = 12'hc00;
    localparam csr_addr_t CSR_CYCLEH    = 12'hc80;

    // Machine ID registers, read only
    localparam csr_addr_t CSR_MVENDORID = 12'hf11;
    localparam csr_addr_t CSR_MARCHID   = 12'hf12;
    localparam csr_addr_t CSR_MIMPID    = 12'hf13;
    localparam csr_addr_t CSR_MHARTID   = 12'hf14;

    // ----------------------------------------
    // Status fields
    // ----------------------------------------

    localparam int STATUS_SIE  = 1;
    localparam int STATUS_MIE  = 3;
    localparam int STATUS_SPIE = 5;
    localparam int STATUS_MPIE = 7;
    localparam int STATUS_SPP  = 8;
    // Low bit of the two-bit MPP field
    localparam int STATUS_MPP  = 11;

    // SIE, MIE, SPIE, MPIE, SPP and MPP
    localparam word_t MSTATUS_WRITE_MASK = 32'h0000_19aa;

    // SIE, SPIE and SPP
    localparam word_t SSTATUS_MASK = 32'h0000_0122;

    // ----------------------------------------
    // Constants
    // ----------------------------------------

    // MXL = 1 (RV32), extensions I and S
    localparam word_t MISA_VALUE = 32'h4004_0100;

    localparam int CAUSE_INT_BIT = 31;

endpackage
